//--- tb.f
csr_pkg.sv
core_pkg.sv
reg_file.sv
csr_file.sv
wb_stage.sv
wb_subsystem_top.sv
wb_assertions.sv
tb_wb_subsystem.sv

//--- tb_wb_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_wb_subsystem;

    localparam int NUM_RANDOM   = 3000;
    localparam int HALT_TIMEOUT = 20;

    logic                  clock;
    logic                  rst_n_i;
    logic                  lsu_valid_i;
    core_pkg::retire_rec_t lsu_rec_i;
    core_pkg::reg_idx_t    dbg_raddr_i;
    core_pkg::xlen_t       dbg_rdata_o;
    logic                  retire_o;
    logic                  halt_o;

    // reference model state after each rising edge
    core_pkg::xlen_t       m_regs [0:31];
    core_pkg::xlen_t       m_csr [0:4];
    logic                  m_valid;
    logic                  m_halt;
    core_pkg::retire_rec_t m_rec;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          m_accepted;
    int          dut_retired;

    wb_subsystem_top dut (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .lsu_valid_i (lsu_valid_i),
        .lsu_rec_i   (lsu_rec_i),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o),
        .retire_o    (retire_o),
        .halt_o      (halt_o)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    // five known CSRs and one unknown address
    function automatic csr_pkg::csr_addr_t csr_addr_pick(input int sel);
        case (sel)
            0:       return 12'h300;
            1:       return 12'h305;
            2:       return 12'h340;
            3:       return 12'h341;
            4:       return 12'h342;
            default: return 12'h7c0;
        endcase
    endfunction

    function automatic int csr_slot(input csr_pkg::csr_addr_t addr);
        case (addr)
            12'h300: return 0;
            12'h305: return 1;
            12'h340: return 2;
            12'h341: return 3;
            12'h342: return 4;
            default: return -1;
        endcase
    endfunction

    function automatic core_pkg::retire_rec_t random_record();
        core_pkg::retire_rec_t rec;
        logic [31:0]           r;
        r            = next_rand();
        rec.rd_we    = (r[1:0] != 2'b00);
        rec.rd_idx   = r[8:4];
        rec.csr_op   = r[9] ? csr_pkg::csr_op_e'(r[11:10]) : csr_pkg::CSR_NONE;
        rec.csr_addr = csr_addr_pick(int'(r[15:12]) % 6);
        rec.ebreak   = 1'b0;
        rec.rd_data  = next_rand();
        rec.csr_src  = next_rand();
        return rec;
    endfunction

    function automatic core_pkg::retire_rec_t csr_record(input csr_pkg::csr_op_e op,
            input csr_pkg::csr_addr_t addr, input core_pkg::xlen_t src,
            input core_pkg::reg_idx_t rd);
        core_pkg::retire_rec_t rec;
        rec          = '0;
        rec.rd_we    = 1'b1;
        rec.rd_idx   = rd;
        rec.rd_data  = 32'hdead_beef;
        rec.csr_op   = op;
        rec.csr_addr = addr;
        rec.csr_src  = src;
        return rec;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 5; i++) begin
            m_csr[i] = '0;
        end
        m_valid = 1'b0;
        m_halt  = 1'b0;
        m_rec   = '0;
    endtask

    // next state at the coming rising edge
    task automatic predict(input logic strobe, input core_pkg::retire_rec_t rec);
        core_pkg::xlen_t old_v;
        core_pkg::xlen_t new_v;
        int              slot;
        logic            nxt_valid;
        // the strobe in an ebreak commit cycle is already past the ebreak
        nxt_valid = strobe && !m_halt && !(m_valid && m_rec.ebreak);
        if (m_valid && m_rec.ebreak) begin
            m_halt = 1'b1;
        end else if (m_valid) begin
            slot  = csr_slot(m_rec.csr_addr);
            old_v = (slot >= 0) ? m_csr[slot] : '0;
            case (m_rec.csr_op)
                csr_pkg::CSR_WRITE: new_v = m_rec.csr_src;
                csr_pkg::CSR_SET:   new_v = old_v | m_rec.csr_src;
                csr_pkg::CSR_CLEAR: new_v = old_v & ~m_rec.csr_src;
                default:            new_v = old_v;
            endcase
            if (slot >= 0) begin
                m_csr[slot] = new_v;
            end
            if (m_rec.rd_we && m_rec.rd_idx != '0) begin
                m_regs[m_rec.rd_idx] = (m_rec.csr_op != csr_pkg::CSR_NONE) ? old_v
                                                                           : m_rec.rd_data;
            end
        end
        if (nxt_valid) begin
            m_accepted++;
            m_rec = rec;
        end
        m_valid = nxt_valid;
    endtask

    // drive at a falling edge, check at the next one
    task automatic step(input logic strobe, input core_pkg::retire_rec_t rec,
                        input core_pkg::reg_idx_t raddr);
        lsu_valid_i = strobe;
        lsu_rec_i   = rec;
        dbg_raddr_i = raddr;
        predict(strobe, rec);
        @(negedge clock);
        if (retire_o === 1'b1) begin
            dut_retired++;
        end
        check_value("retire_o", m_valid, retire_o);
        check_value("halt_o", m_halt, halt_o);
        check_value($sformatf("dbg_rdata_o[x%0d]", raddr), m_regs[raddr], dbg_rdata_o);
    endtask

    initial begin
        core_pkg::reg_idx_t sweep;
        core_pkg::xlen_t    burst_exp [1:5];
        logic [31:0]        r;
        int                 waited;
        rng_state   = 32'd70730;
        errors      = 0;
        checks      = 0;
        m_accepted  = 0;
        dut_retired = 0;
        sweep       = '0;
        rst_n_i     = 1'b0;
        lsu_valid_i = 1'b0;
        lsu_rec_i   = '0;
        dbg_raddr_i = '0;
        model_reset();
        repeat (4) @(negedge clock);
        rst_n_i = 1'b1;

        // reset state, every register reads zero
        for (int i = 0; i < 32; i++) begin
            step(1'b0, '0, core_pkg::reg_idx_t'(i));
        end

        // back-to-back read-modify-write on mscratch, then an unknown CSR
        step(1'b1, csr_record(csr_pkg::CSR_WRITE, 12'h340, 32'ha5a5_0f0f, 5'd1), 5'd0);
        step(1'b1, csr_record(csr_pkg::CSR_SET, 12'h340, 32'h0000_ffff, 5'd2), 5'd0);
        step(1'b1, csr_record(csr_pkg::CSR_CLEAR, 12'h340, 32'hff00_0000, 5'd3), 5'd0);
        step(1'b1, csr_record(csr_pkg::CSR_SET, 12'h340, 32'h0000_0000, 5'd4), 5'd0);
        step(1'b1, csr_record(csr_pkg::CSR_WRITE, 12'h7c0, 32'h1234_5678, 5'd5), 5'd0);
        step(1'b0, '0, 5'd0);
        burst_exp[1] = 32'h0000_0000;
        burst_exp[2] = 32'ha5a5_0f0f;
        burst_exp[3] = 32'ha5a5_ffff;
        burst_exp[4] = 32'h00a5_ffff;
        burst_exp[5] = 32'h0000_0000;
        for (int k = 1; k <= 5; k++) begin
            step(1'b0, '0, core_pkg::reg_idx_t'(k));
            check_value($sformatf("csr burst x%0d", k), burst_exp[k], dbg_rdata_o);
        end

        // plain write aimed at x0, x0 keeps reading zero
        step(1'b1, csr_record(csr_pkg::CSR_NONE, 12'h000, 32'h0000_0000, 5'd0), 5'd0);
        step(1'b0, '0, 5'd0);
        step(1'b0, '0, 5'd0);

        // random traffic, strobe about three cycles in four
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_rand();
            step(r[1:0] != 2'b00, random_record(), sweep);
            sweep++;
        end

        // ebreak, then traffic that must be dropped
        lsu_rec_i        = random_record();
        lsu_rec_i.ebreak = 1'b1;
        lsu_rec_i.rd_we  = 1'b1;
        step(1'b1, lsu_rec_i, sweep);
        sweep++;
        waited = 0;
        while (halt_o !== 1'b1 && waited < HALT_TIMEOUT) begin
            step(1'b1, random_record(), sweep);
            sweep++;
            waited++;
        end
        if (halt_o !== 1'b1) begin
            errors++;
            $display("timeout: halt_o did not rise within %0d cycles of the ebreak",
                     HALT_TIMEOUT);
        end
        for (int i = 0; i < 40; i++) begin
            step(1'b1, random_record(), sweep);
            sweep++;
        end
        check_value("retired count", m_accepted, dut_retired);

        errors = errors + int'(dut.u_wb_assertions.fail_count);
        $display("retired=%0d checks=%0d errors=%0d", dut_retired, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_wb_subsystem

`default_nettype wire

//--- wb_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module wb_assertions (
    input wire                     clock,
    input wire                     rst_n_i,
    input wire                     retire_i,
    input wire                     halt_i,
    // register file write port
    input wire                     reg_we_i,
    input wire core_pkg::reg_idx_t reg_idx_i,
    // debug read port
    input wire core_pkg::reg_idx_t dbg_raddr_i,
    input wire core_pkg::xlen_t    dbg_rdata_i
);

    // failures seen so far, read by the testbench at the end
    int unsigned fail_count = 0;

    // nothing retires once halted
    no_retire_when_halted: assert property (
        @(posedge clock) disable iff (!rst_n_i) !(retire_i && halt_i))
    else begin
        $error("retire_o is high while halt_o is high");
        fail_count++;
    end

    // halt only clears through reset
    halt_is_sticky: assert property (
        @(posedge clock) disable iff (!rst_n_i) halt_i |=> halt_i)
    else begin
        $error("halt_o fell without a reset");
        fail_count++;
    end

    // a write aimed at x0 leaves it reading zero
    x0_stays_zero: assert property (
        @(posedge clock) disable iff (!rst_n_i)
        (reg_we_i && reg_idx_i == '0) ##1 (dbg_raddr_i == '0) |-> (dbg_rdata_i == '0))
    else begin
        $error("x0 reads nonzero after a write to index 0");
        fail_count++;
    end

endmodule : wb_assertions

bind wb_subsystem_top wb_assertions u_wb_assertions (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .retire_i    (retire_o),
    .halt_i      (halt_o),
    .reg_we_i    (reg_we),
    .reg_idx_i   (reg_idx),
    .dbg_raddr_i (dbg_raddr_i),
    .dbg_rdata_i (dbg_rdata_o)
);

`default_nettype wire

//--- wb_subsystem_top.sv
`timescale 1ns/100ps
`default_nettype none

module wb_subsystem_top (
    input  wire                        clock,
    input  wire                        rst_n_i,
    // retiring instructions from the LSU
    input  wire                        lsu_valid_i,
    input  wire core_pkg::retire_rec_t lsu_rec_i,
    // debug read of the general registers
    input  wire core_pkg::reg_idx_t    dbg_raddr_i,
    output core_pkg::xlen_t            dbg_rdata_o,
    output logic                       retire_o,
    output logic                       halt_o
);

    // write-back stage to CSR file
    csr_pkg::csr_req_t  csr_req;
    core_pkg::xlen_t    csr_old;

    // write-back stage to register file
    logic               reg_we;
    core_pkg::reg_idx_t reg_idx;
    core_pkg::xlen_t    reg_data;

    wb_stage u_wb_stage (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .lsu_valid_i (lsu_valid_i),
        .lsu_rec_i   (lsu_rec_i),
        .csr_old_i   (csr_old),
        .csr_req_o   (csr_req),
        .reg_we_o    (reg_we),
        .reg_idx_o   (reg_idx),
        .reg_data_o  (reg_data),
        .retire_o    (retire_o),
        .halt_o      (halt_o)
    );

    reg_file u_reg_file (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .we_i    (reg_we),
        .widx_i  (reg_idx),
        .wdata_i (reg_data),
        .raddr_i (dbg_raddr_i),
        .rdata_o (dbg_rdata_o)
    );

    csr_file u_csr_file (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .req_i   (csr_req),
        .old_o   (csr_old)
    );

endmodule : wb_subsystem_top

`default_nettype wire

//--- wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
    input  wire                   clock,
    input  wire                   rst_n_i,
    // retiring instruction from the LSU, one-cycle strobe
    input  wire                   lsu_valid_i,
    input  wire core_pkg::retire_rec_t lsu_rec_i,
    // old value of the addressed CSR
    input  wire core_pkg::xlen_t  csr_old_i,
    output csr_pkg::csr_req_t     csr_req_o,
    // register file write port
    output logic                  reg_we_o,
    output core_pkg::reg_idx_t    reg_idx_o,
    output core_pkg::xlen_t       reg_data_o,
    output logic                  retire_o,
    output logic                  halt_o
);

    // write-back register
    logic                  valid_q;
    core_pkg::retire_rec_t rec_q;

    // sticky halt flag
    logic                  halt_q;

    logic                  ebreak_commit;
    logic                  accept;
    logic                  is_csr;

    // ebreak in its commit cycle
    assign ebreak_commit = valid_q && rec_q.ebreak;

    // halt is set at the end of the ebreak commit cycle, so a strobe in that
    // same cycle is already past the ebreak and gets dropped too
    assign accept = lsu_valid_i && !halt_q && !ebreak_commit;

    assign is_csr = (rec_q.csr_op != csr_pkg::CSR_NONE);

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    // payload only follows the strobe
    always_ff @(posedge clock) begin
        if (accept) begin
            rec_q <= lsu_rec_i;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            halt_q <= 1'b0;
        end else if (ebreak_commit) begin
            halt_q <= 1'b1;
        end
    end

    // CSR request, an ebreak record touches no CSR
    always_comb begin
        csr_req_o.en   = valid_q && is_csr && !rec_q.ebreak;
        csr_req_o.op   = rec_q.csr_op;
        csr_req_o.addr = rec_q.csr_addr;
        csr_req_o.src  = rec_q.csr_src;
    end

    // register write, CSR instructions return the old CSR value
    assign reg_we_o   = valid_q && rec_q.rd_we && !rec_q.ebreak;
    assign reg_idx_o  = rec_q.rd_idx;
    assign reg_data_o = is_csr ? csr_old_i : rec_q.rd_data;

    assign retire_o = valid_q;
    assign halt_o   = halt_q;

endmodule : wb_stage

`default_nettype wire

//--- csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file (
    input  wire                     clock,
    input  wire                     rst_n_i,
    // request from the write-back stage
    input  wire csr_pkg::csr_req_t  req_i,
    // old value of the addressed CSR, zero if unknown
    output core_pkg::xlen_t         old_o
);

    // machine CSRs
    core_pkg::xlen_t mstatus_q;
    core_pkg::xlen_t mtvec_q;
    core_pkg::xlen_t mscratch_q;
    core_pkg::xlen_t mepc_q;
    core_pkg::xlen_t mcause_q;

    core_pkg::xlen_t old_val;
    core_pkg::xlen_t new_val;
    logic            known;
    logic            wr_en;

    // address decode and old-value read
    always_comb begin
        known   = 1'b1;
        old_val = '0;
        case (req_i.addr)
            csr_pkg::CSR_MSTATUS:  old_val = mstatus_q;
            csr_pkg::CSR_MTVEC:    old_val = mtvec_q;
            csr_pkg::CSR_MSCRATCH: old_val = mscratch_q;
            csr_pkg::CSR_MEPC:     old_val = mepc_q;
            csr_pkg::CSR_MCAUSE:   old_val = mcause_q;
            default: begin
                known   = 1'b0;
                old_val = '0;
            end
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (req_i.op)
            csr_pkg::CSR_WRITE: new_val = req_i.src;
            csr_pkg::CSR_SET:   new_val = old_val | req_i.src;
            csr_pkg::CSR_CLEAR: new_val = old_val & ~req_i.src;
            default:            new_val = old_val;
        endcase
    end

    // unknown addresses take no write
    assign wr_en = req_i.en && known;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (wr_en) begin
            case (req_i.addr)
                csr_pkg::CSR_MSTATUS:  mstatus_q  <= new_val;
                csr_pkg::CSR_MTVEC:    mtvec_q    <= new_val;
                csr_pkg::CSR_MSCRATCH: mscratch_q <= new_val;
                csr_pkg::CSR_MEPC:     mepc_q     <= new_val;
                csr_pkg::CSR_MCAUSE:   mcause_q   <= new_val;
                default: begin
                    mstatus_q <= mstatus_q;
                end
            endcase
        end
    end

    assign old_o = old_val;

endmodule : csr_file

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                  clock,
    input  wire                  rst_n_i,
    // write port, commits at the clock edge
    input  wire                  we_i,
    input  wire core_pkg::reg_idx_t widx_i,
    input  wire core_pkg::xlen_t wdata_i,
    // asynchronous read port
    input  wire core_pkg::reg_idx_t raddr_i,
    output core_pkg::xlen_t      rdata_o
);

    // x0 has no storage
    core_pkg::xlen_t regs_q [1:core_pkg::NUM_REGS-1];

    logic wr_en;

    // writes to x0 are dropped here
    assign wr_en = we_i && (widx_i != '0);

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[widx_i] <= wdata_i;
        end
    end

    // no bypass, a same-cycle write shows up next cycle
    always_comb begin
        if (raddr_i == '0) begin
            rdata_o = '0;
        end else begin
            rdata_o = regs_q[raddr_i];
        end
    end

endmodule : reg_file

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

// types shared by the pipeline stages of the core
// retire_rec_t carries CSR fields, so csr_pkg compiles first
package core_pkg;

    // data path width of RV32
    localparam int XLEN = 32;

    // general register file depth
    localparam int NUM_REGS = 32;

    // register index width follows from the depth
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    // one data word, register or CSR value
    typedef logic [XLEN-1:0] xlen_t;

    // general register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // one retiring instruction as handed over by the LSU
    typedef struct packed {
        // destination register write
        logic                 rd_we;
        reg_idx_t             rd_idx;
        // result computed upstream, unused for CSR instructions
        xlen_t                rd_data;
        // CSR access, CSR_NONE for plain instructions
        csr_pkg::csr_op_e     csr_op;
        csr_pkg::csr_addr_t   csr_addr;
        xlen_t                csr_src;
        // stops retirement until reset
        logic                 ebreak;
    } retire_rec_t;

endpackage : core_pkg

`default_nettype wire

//--- csr_pkg.sv
`default_nettype none

// machine CSR definitions
package csr_pkg;

    localparam int CSR_ADDR_W = 12;
    // CSR width, same as XLEN on RV32
    localparam int CSR_DATA_W = 32;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    // read-modify-write operation of a CSR instruction
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // supported machine CSRs
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // request from the write-back stage to the CSR file
    typedef struct packed {
        logic      en;
        csr_op_e   op;
        csr_addr_t addr;
        csr_data_t src;
    } csr_req_t;

endpackage : csr_pkg

`default_nettype wire
